// ==== ethBus_cfg.svh ====
// Reset timing and control-bus decode for the KSZ8851 bus controller.
// Cycle counts are scaled down for simulation; real silicon needs far longer.
// ETH_CTRL_REG_ADDR must match the address the control bus uses for this block.
`ifndef ETH_BUS_CFG_SVH
`define ETH_BUS_CFG_SVH

// ------------------------------
// reset sequence
// ------------------------------

// chip reset held low this many sysclk cycles
// on hardware this is about 10 ms (491520 cycles at 49.152 MHz)
`define ETH_RST_ASSERT_CYCLES 20

// wait after reset release before asking the host layer to init
// on hardware the chip wants about 50 ms of warm-up here
`define ETH_RST_WAIT_CYCLES 40

// ------------------------------
// control-bus decode
// ------------------------------
`define ETH_CTRL_REG_ADDR 16'h000C  // main block, ethernet access register

`endif

// ==== ethBusPkg.sv ====
// Types shared by the KSZ8851 bus controller.
// byteEnableAddr does not handle 16-bit accesses at odd offsets.
package ethBusPkg;

    // address view of the bus word, as the chip expects it in the cmd phase
    typedef struct packed {
        logic [3:0] byteEn;   // byte enables BE[3:0] on sd[15:12]
        logic [3:0] zero;     // unused, kept at 0
        logic [7:0] offset;   // register offset, low bits repeated
    } sdAddr_t;

    // one bus word, read either as data or as an address
    typedef union packed {
        logic [15:0] data;
        sdAddr_t     addr;
    } sdWord_t;

    // 32-bit control-bus write word
    typedef struct packed {
        logic [3:0]  spare;
        logic        isDma;    // bit 27
        logic        isReset;  // bit 26, restarts the chip reset sequence
        logic        isWrite;  // bit 25, 1 = write
        logic        isWord;   // bit 24, 1 = 16-bit access
        logic [7:0]  offset;   // bits 23:16
        logic [15:0] data;     // bits 15:0
    } ctrlWord_t;

    // chip splits its register space into 32-bit chunks, BE picks the lanes
    function automatic sdWord_t byteEnableAddr(input logic [7:0] offset, input logic isWord);
        sdWord_t    word;
        logic [1:0] tail;
        tail = offset[1:0];
        word.addr.byteEn[0] = (tail == 2'd0);
        word.addr.byteEn[1] = (isWord && tail == 2'd0) || (!isWord && tail == 2'd1);
        word.addr.byteEn[2] = (tail == 2'd2);
        word.addr.byteEn[3] = (isWord && tail == 2'd2) || (!isWord && tail == 2'd3);
        word.addr.zero      = 4'h0;
        word.addr.offset    = offset;
        return word;
    endfunction

endpackage

// ==== ethReqIf.sv ====
// One access request and its completion, front end to bus engine.
// start and restart are single-cycle; start only while idle is high.
`timescale 1ns/10ps

interface ethReqIf;

    // front end -> engine
    logic        start;     // begin one access, fields valid this cycle
    logic        isDma;
    logic        isWrite;
    logic        isWord;
    logic [7:0]  regAddr;   // ignored for DMA
    logic [15:0] wrData;    // ignored for reads
    logic        restart;   // back to the chip reset sequence, wins over start

    // engine -> front end
    logic        idle;      // level, ready for a new start
    logic        readDone;  // pulse, rdData just captured
    logic [15:0] rdData;

    modport arbiter (
        output start, isDma, isWrite, isWord, regAddr, wrData, restart,
        input  idle, readDone, rdData
    );

    modport engine (
        input  start, isDma, isWrite, isWord, regAddr, wrData, restart,
        output idle, readDone, rdData
    );

endinterface

// ==== ethReqArbiter.sv ====
// Request front end: host command port and control-bus register writes.
// Control bus wins a tie; a control write while busy is dropped and flags ethError.
// Host must drop cmdReq after cmdAck before it can issue again.
`timescale 1ns/10ps
`include "ethBus_cfg.svh"

module ethReqArbiter (
    input  logic        sysclk,
    input  logic        reset,
    input  logic        initAck,
    input  logic        initDone,    // engine finished the reset sequence
    input  logic        cmdReq,
    input  logic        isDma,
    input  logic        isWrite,
    input  logic        isWord,
    input  logic [7:0]  regAddr,
    input  logic [15:0] dataIn,
    input  logic        ctrlWen,
    input  logic [15:0] ctrlAddr,
    input  logic [31:0] ctrlWdata,
    output logic        initReq,
    output logic        cmdAck,
    output logic        dataValid,
    output logic [15:0] dataOut,
    output logic        ethError,
    output logic [15:0] ethData,
    ethReqIf.arbiter    req
);

    ethBusPkg::ctrlWord_t ctrlWord;
    logic ctrlHit;    // control-bus write aimed at us
    logic ctrlStart;
    logic hostStart;
    logic fromHost;   // source of the access in flight

    assign ctrlWord = ctrlWdata;
    assign ctrlHit  = ctrlWen && (ctrlAddr == `ETH_CTRL_REG_ADDR);

    // ------------------------------
    // source select
    // ------------------------------
    assign req.restart = ctrlHit && ctrlWord.isReset;
    assign ctrlStart   = ctrlHit && !ctrlWord.isReset && req.idle;
    assign hostStart   = cmdReq && !cmdAck && req.idle && !ctrlHit;  // ctrl has priority
    assign req.start   = ctrlStart || hostStart;

    // fields follow the winner, don't care when start is low
    assign req.isDma   = ctrlHit ? ctrlWord.isDma   : isDma;
    assign req.isWrite = ctrlHit ? ctrlWord.isWrite : isWrite;
    assign req.isWord  = ctrlHit ? ctrlWord.isWord  : isWord;
    assign req.regAddr = ctrlHit ? ctrlWord.offset  : regAddr;
    assign req.wrData  = ctrlHit ? ctrlWord.data    : dataIn;

    // ------------------------------
    // handshake and flags
    // ------------------------------
    always_ff @(posedge sysclk or negedge reset) begin
        if (!reset) begin
            initReq   <= 1'b0;
            cmdAck    <= 1'b0;
            dataValid <= 1'b0;
            ethError  <= 1'b0;
            fromHost  <= 1'b0;
        end else if (req.restart) begin
            initReq   <= 1'b0;   // fresh initReq comes after the new sequence
            cmdAck    <= 1'b0;
            dataValid <= 1'b0;
            ethError  <= 1'b0;
        end else begin
            if (hostStart) begin
                cmdAck   <= 1'b1;
                fromHost <= 1'b1;
            end else if (ctrlStart) begin
                fromHost <= 1'b0;
            end

            if (ctrlStart)
                ethError <= 1'b0;
            else if (ctrlHit)
                ethError <= 1'b1;   // engine busy, request lost

            // host released the request, drop ack and valid together
            if (cmdAck && !cmdReq) begin
                cmdAck    <= 1'b0;
                dataValid <= 1'b0;
            end
            if (req.readDone && fromHost)
                dataValid <= 1'b1;

            if (initAck)
                initReq <= 1'b0;
            if (initDone)
                initReq <= 1'b1;
        end
    end

    // read data and control-bus mirror
    always_ff @(posedge sysclk) begin
        if (req.readDone && fromHost)
            dataOut <= req.rdData;
        if (ctrlStart)
            ethData <= ctrlWord.data;
        else if (req.readDone && !fromHost)
            ethData <= req.rdData;
    end

endmodule

// ==== ethBusEngine.sv ====
// Chip reset sequencer and bus-cycle FSM for the KSZ8851 16-bit bus.
// Every strobe is low two cycles; sd is driven whenever ethRdn is high.
// Does not re-check start against idle. restart aborts any cycle at once.
// Cycles start..idle: reg write 8, reg read 8, DMA write 3, DMA read 4.
`timescale 1ns/10ps
`include "ethBus_cfg.svh"

module ethBusEngine (
    input  logic        sysclk,
    input  logic        reset,
    output logic        ethRstn,   // chip reset, active low
    output logic        ethCmd,    // 1 = address phase, 0 = data
    output logic        ethRdn,
    output logic        ethWrn,
    inout  wire  [15:0] sd,
    output logic        initDone,  // pulse, reset sequence complete
    ethReqIf.engine     req
);

    localparam int RST_MAX = (`ETH_RST_ASSERT_CYCLES > `ETH_RST_WAIT_CYCLES) ?
                             `ETH_RST_ASSERT_CYCLES : `ETH_RST_WAIT_CYCLES;
    localparam int CNT_W   = $clog2(RST_MAX + 1);

    // ------------------------------
    // state codes
    // ------------------------------
    localparam logic [3:0] ST_RST_ASSERT  = 4'd0;
    localparam logic [3:0] ST_RST_WAIT    = 4'd1;
    localparam logic [3:0] ST_IDLE        = 4'd2;
    localparam logic [3:0] ST_ADDR_SETUP  = 4'd3;  // address on sd, cmd high
    localparam logic [3:0] ST_ADDR_STROBE = 4'd4;  // wrn low, 2 cycles
    localparam logic [3:0] ST_ADDR_HOLD   = 4'd5;  // wrn back high, address held
    localparam logic [3:0] ST_WRITE_SETUP = 4'd6;  // data on sd, cmd low
    localparam logic [3:0] ST_WRITE_STB   = 4'd7;  // wrn low, 2 cycles
    localparam logic [3:0] ST_READ_STB    = 4'd8;  // rdn low, 2 cycles, chip drives sd
    localparam logic [3:0] ST_READ_TURN   = 4'd9;  // bus turnaround after read

    logic [3:0]         state;
    logic [CNT_W-1:0]   count;     // reset delays, bit 0 also times the strobes
    logic               curWrite;  // latched at start
    logic [15:0]        curData;
    ethBusPkg::sdWord_t sdReg;     // word we put on the bus
    logic               capture;

    // release sd while the chip is reading out
    assign sd = ethRdn ? sdReg.data : 16'hzzzz;

    assign req.idle = (state == ST_IDLE);
    assign initDone = (state == ST_RST_WAIT) &&
                      (count == CNT_W'(`ETH_RST_WAIT_CYCLES - 1));
    assign capture  = (state == ST_READ_STB) && count[0];  // end of the rdn low phase

    always_ff @(posedge sysclk or negedge reset) begin
        if (!reset) begin
            state        <= ST_RST_ASSERT;
            count        <= '0;
            ethRstn      <= 1'b0;
            ethCmd       <= 1'b0;
            ethRdn       <= 1'b1;
            ethWrn       <= 1'b1;
            curWrite     <= 1'b0;
            req.readDone <= 1'b0;
        end else if (req.restart) begin
            state        <= ST_RST_ASSERT;
            count        <= '0;
            ethRstn      <= 1'b0;
            ethCmd       <= 1'b0;
            ethRdn       <= 1'b1;
            ethWrn       <= 1'b1;
            req.readDone <= 1'b0;
        end else begin
            req.readDone <= 1'b0;
            case (state)
                ST_RST_ASSERT: begin
                    ethWrn <= 1'b1;
                    ethRdn <= 1'b1;
                    if (count == CNT_W'(`ETH_RST_ASSERT_CYCLES - 1)) begin
                        ethRstn <= 1'b1;   // release chip
                        count   <= '0;
                        state   <= ST_RST_WAIT;
                    end else begin
                        count <= count + 1'b1;
                    end
                end

                ST_RST_WAIT: begin
                    if (initDone) begin
                        count <= '0;
                        state <= ST_IDLE;
                    end else begin
                        count <= count + 1'b1;
                    end
                end

                ST_IDLE: begin
                    if (req.start) begin
                        curWrite <= req.isWrite;
                        count    <= '0;
                        if (req.isDma && req.isWrite) begin
                            ethCmd <= 1'b0;
                            ethWrn <= 1'b0;      // data goes out with the strobe
                            state  <= ST_WRITE_STB;
                        end else if (req.isDma) begin
                            ethCmd <= 1'b0;
                            ethRdn <= 1'b0;
                            state  <= ST_READ_STB;
                        end else begin
                            ethCmd <= 1'b1;
                            state  <= ST_ADDR_SETUP;
                        end
                    end
                end

                ST_ADDR_SETUP: begin
                    ethWrn <= 1'b0;
                    count  <= '0;
                    state  <= ST_ADDR_STROBE;
                end

                ST_ADDR_STROBE: begin
                    if (!count[0]) begin
                        count <= CNT_W'(1);
                    end else begin
                        ethWrn <= 1'b1;          // chip latches address here
                        state  <= ST_ADDR_HOLD;
                    end
                end

                ST_ADDR_HOLD: begin
                    ethCmd <= 1'b0;
                    count  <= '0;
                    if (curWrite) begin
                        state <= ST_WRITE_SETUP;
                    end else begin
                        ethRdn <= 1'b0;          // sd released from next cycle
                        state  <= ST_READ_STB;
                    end
                end

                ST_WRITE_SETUP: begin
                    ethWrn <= 1'b0;
                    state  <= ST_WRITE_STB;
                end

                ST_WRITE_STB: begin
                    if (!count[0]) begin
                        count <= CNT_W'(1);
                    end else begin
                        ethWrn <= 1'b1;
                        state  <= ST_IDLE;
                    end
                end

                ST_READ_STB: begin
                    if (!count[0]) begin
                        count <= CNT_W'(1);
                    end else begin
                        ethRdn       <= 1'b1;
                        req.readDone <= 1'b1;    // rdData loaded this edge
                        state        <= ST_READ_TURN;
                    end
                end

                ST_READ_TURN: state <= ST_IDLE;

                default: state <= ST_RST_ASSERT;
            endcase
        end
    end

    // ------------------------------
    // bus word and read data
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (req.idle && req.start) begin
            curData <= req.wrData;
            if (req.isDma)
                sdReg.data <= req.wrData;
            else
                sdReg <= ethBusPkg::byteEnableAddr(req.regAddr, req.isWord);
        end else if (state == ST_ADDR_HOLD) begin
            sdReg.data <= curData;   // only seen on the bus for writes
        end
        if (capture)
            req.rdData <= sd;
    end

endmodule

// ==== ksz8851Ctrl.sv ====
// Top level of the KSZ8851 bus controller.
// Interrupt and power-management pins of the chip are not handled.
// initReq must be acknowledged before the host layer starts its init.
`timescale 1ns/10ps

module ksz8851Ctrl (
    input  logic        sysclk,
    input  logic        reset,
    // chip side
    output logic        ethRstn,
    output logic        ethCmd,
    output logic        ethRdn,
    output logic        ethWrn,
    inout  wire  [15:0] sd,
    // host command port
    output logic        initReq,
    input  logic        initAck,
    input  logic        cmdReq,
    output logic        cmdAck,
    output logic        dataValid,
    input  logic        isDma,
    input  logic        isWrite,
    input  logic        isWord,
    input  logic [7:0]  regAddr,
    input  logic [15:0] dataIn,
    output logic [15:0] dataOut,
    output logic        ethError,
    output logic        isIdle,
    // control bus
    input  logic        ctrlWen,
    input  logic [15:0] ctrlAddr,
    input  logic [31:0] ctrlWdata,
    output logic [15:0] ethData
);

    logic initDone;   // engine -> arbiter, reset sequence complete

    ethReqIf reqBus ();

    assign isIdle = reqBus.idle;

    ethReqArbiter ethReqArbiter_i (
        .sysclk    (sysclk),
        .reset     (reset),
        .initAck   (initAck),
        .initDone  (initDone),
        .cmdReq    (cmdReq),
        .isDma     (isDma),
        .isWrite   (isWrite),
        .isWord    (isWord),
        .regAddr   (regAddr),
        .dataIn    (dataIn),
        .ctrlWen   (ctrlWen),
        .ctrlAddr  (ctrlAddr),
        .ctrlWdata (ctrlWdata),
        .initReq   (initReq),
        .cmdAck    (cmdAck),
        .dataValid (dataValid),
        .dataOut   (dataOut),
        .ethError  (ethError),
        .ethData   (ethData),
        .req       (reqBus.arbiter)
    );

    ethBusEngine ethBusEngine_i (
        .sysclk   (sysclk),
        .reset    (reset),
        .ethRstn  (ethRstn),
        .ethCmd   (ethCmd),
        .ethRdn   (ethRdn),
        .ethWrn   (ethWrn),
        .sd       (sd),
        .initDone (initDone),
        .req      (reqBus.engine)
    );

endmodule

// ==== tbClock.sv ====
// Clock and reset source for the testbench.
// 100 ns period, reset low for the first 10 rising edges.
`timescale 1ns/10ps

module tbClock (
    output logic sysclk,
    output logic reset
);

    initial begin
        sysclk = 1'b0;
        forever #50 sysclk = ~sysclk;   // 100 ns period
    end

    initial begin
        reset = 1'b0;
        repeat (10) @(posedge sysclk);
        reset <= 1'b1;   // released on a rising edge
    end

endmodule

// ==== ksz8851Model.sv ====
// Behavioural KSZ8851 bus model, sampled on sysclk.
// Register bytes live at {offset[7:2], lane}; BE0/BE2 use sd[7:0], BE1/BE3 sd[15:8].
// A data phase with no address latched before it goes to the DMA FIFO.
`timescale 1ns/10ps

module ksz8851Model (
    input  logic        sysclk,
    input  logic        ethRstn,
    input  logic        ethCmd,
    input  logic        ethRdn,
    input  logic        ethWrn,
    inout  wire  [15:0] sd,
    output int          accessCount,  // completed data phases
    output logic        badAccess     // sticky, illegal byte enables seen
);

    logic [7:0]         regMem [0:255];
    logic [15:0]        fifo [$];
    ethBusPkg::sdWord_t addrWord;      // last latched address word
    logic               addrValid;
    logic               wrnLast;
    logic               rdnLast;
    logic [15:0]        rdWord;

    assign sd = ethRdn ? 16'hzzzz : rdWord;   // chip drives only while rdn low

    // data for the latched address, or the FIFO head for DMA
    function automatic logic [15:0] readValue();
        logic [7:0] base;
        logic [7:0] lo;
        logic [7:0] hi;
        base = {addrWord.addr.offset[7:2], 2'b00};
        lo   = 8'h00;
        hi   = 8'h00;
        if (!addrValid)
            return (fifo.size() > 0) ? fifo[0] : 16'hdead;
        if (addrWord.addr.byteEn[0]) lo = regMem[base];
        if (addrWord.addr.byteEn[1]) hi = regMem[base + 8'd1];
        if (addrWord.addr.byteEn[2]) lo = regMem[base + 8'd2];
        if (addrWord.addr.byteEn[3]) hi = regMem[base + 8'd3];
        return {hi, lo};
    endfunction

    initial begin
        for (int i = 0; i < 256; i++)
            regMem[i] = i[7:0] ^ 8'h5a;   // fill depends on whole address
        addrValid   = 1'b0;
        wrnLast     = 1'b1;
        rdnLast     = 1'b1;
        rdWord      = 16'h0000;
        accessCount = 0;
        badAccess   = 1'b0;
    end

    always @(posedge sysclk) begin
        wrnLast <= ethWrn;
        rdnLast <= ethRdn;
        if (!ethRstn) begin
            addrValid = 1'b0;   // chip in reset, no latched address
        end else if (ethWrn && !wrnLast) begin
            if (ethCmd) begin
                addrWord  = sd;
                addrValid = 1'b1;
                case (addrWord.addr.byteEn)
                    4'b0001, 4'b0011, 4'b0010, 4'b0100, 4'b1100, 4'b1000: ;
                    default: begin
                        badAccess <= 1'b1;
                        $display("model: illegal byte enable pattern %b at offset %h",
                                 addrWord.addr.byteEn, addrWord.addr.offset);
                    end
                endcase
            end else if (addrValid) begin
                if (addrWord.addr.byteEn[0]) regMem[{addrWord.addr.offset[7:2], 2'd0}] = sd[7:0];
                if (addrWord.addr.byteEn[1]) regMem[{addrWord.addr.offset[7:2], 2'd1}] = sd[15:8];
                if (addrWord.addr.byteEn[2]) regMem[{addrWord.addr.offset[7:2], 2'd2}] = sd[7:0];
                if (addrWord.addr.byteEn[3]) regMem[{addrWord.addr.offset[7:2], 2'd3}] = sd[15:8];
                addrValid = 1'b0;
                accessCount <= accessCount + 1;
            end else begin
                fifo.push_back(sd);   // DMA write
                accessCount <= accessCount + 1;
            end
        end
        if (ethRstn && !ethRdn && rdnLast)
            rdWord <= readValue();    // ready well before the capture edge
        if (ethRstn && ethRdn && !rdnLast) begin
            if (addrValid)
                addrValid = 1'b0;
            else if (fifo.size() > 0)
                void'(fifo.pop_front());
            accessCount <= accessCount + 1;
        end
    end

endmodule

// ==== ksz8851Tb.sv ====
// Testbench for the KSZ8851 bus controller, table driven.
// Host rows use the cmdReq/cmdAck handshake, control rows a one-cycle ctrlWen.
// Word accesses at odd offsets are not exercised.
`timescale 1ns/10ps
`include "ethBus_cfg.svh"

module ksz8851Tb;

    typedef struct packed {
        logic        isCtrl;   // 1 = control bus, 0 = host
        logic        dma;
        logic        wr;
        logic        word;
        logic [7:0]  off;
        logic [15:0] data;
        logic [15:0] expRead;  // read rows only
    } rowT;

    localparam int NROWS = 16;

    logic sysclk, reset, initAck, cmdReq, isDma, isWrite, isWord, ctrlWen;
    logic [7:0]  regAddr;
    logic [15:0] dataIn, ctrlAddr, dataOut, ethData;
    logic [31:0] ctrlWdata;
    logic ethRstn, ethCmd, ethRdn, ethWrn, initReq, cmdAck, dataValid, ethError, isIdle;
    wire  [15:0] sd;
    int   accessCount;
    logic badAccess;

    rowT         rows [NROWS];
    logic [7:0]  mirror [0:255];   // expected register bytes
    logic [15:0] dmaExp [$];       // expected FIFO contents
    int   valueErrors = 0;
    int   expAccess   = 0;
    logic inDma       = 1'b0;

    tbClock tbClock_i (.sysclk(sysclk), .reset(reset));

    ksz8851Ctrl ksz8851Ctrl_i (
        .sysclk(sysclk), .reset(reset), .ethRstn(ethRstn), .ethCmd(ethCmd),
        .ethRdn(ethRdn), .ethWrn(ethWrn), .sd(sd), .initReq(initReq),
        .initAck(initAck), .cmdReq(cmdReq), .cmdAck(cmdAck), .dataValid(dataValid),
        .isDma(isDma), .isWrite(isWrite), .isWord(isWord), .regAddr(regAddr),
        .dataIn(dataIn), .dataOut(dataOut), .ethError(ethError), .isIdle(isIdle),
        .ctrlWen(ctrlWen), .ctrlAddr(ctrlAddr), .ctrlWdata(ctrlWdata), .ethData(ethData)
    );

    ksz8851Model ksz8851Model_i (
        .sysclk(sysclk), .ethRstn(ethRstn), .ethCmd(ethCmd), .ethRdn(ethRdn),
        .ethWrn(ethWrn), .sd(sd), .accessCount(accessCount), .badAccess(badAccess)
    );

    // ------------------------------
    // compare tasks
    // ------------------------------
    task automatic checkWord(input string name, input ethBusPkg::sdWord_t got,
                             input ethBusPkg::sdWord_t exp);
        if (got.data !== exp.data) begin
            valueErrors++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, got.data, exp.data);
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            valueErrors++;
            $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic checkCount(input string name, input int got, input int exp);
        if (got != exp) begin
            valueErrors++;
            $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    // ------------------------------
    // expected-value mirror
    // ------------------------------
    // byte access at an odd offset uses the high byte, even the low byte
    function automatic logic [15:0] mirrorRead(input logic [7:0] off, input logic word);
        if (word)
            return {mirror[{off[7:1], 1'b1}], mirror[{off[7:1], 1'b0}]};
        if (off[0])
            return {mirror[off], 8'h00};
        return {8'h00, mirror[off]};
    endfunction

    task automatic mirrorWrite(input logic [7:0] off, input logic word, input logic [15:0] d);
        if (word) begin
            mirror[{off[7:1], 1'b0}] = d[7:0];
            mirror[{off[7:1], 1'b1}] = d[15:8];
        end else if (off[0]) begin
            mirror[off] = d[15:8];
        end else begin
            mirror[off] = d[7:0];
        end
    endtask

    // wait for initReq, then acknowledge it
    task automatic ackInit();
        while (!initReq) @(negedge sysclk);
        @(posedge sysclk) initAck <= 1'b1;
        @(posedge sysclk) initAck <= 1'b0;
        @(negedge sysclk);
        checkFlag("initReq", initReq, 1'b0);
    endtask

    task automatic ctrlWrite(input logic [31:0] w);
        @(posedge sysclk);
        ctrlWen   <= 1'b1;
        ctrlAddr  <= `ETH_CTRL_REG_ADDR;
        ctrlWdata <= w;
        @(posedge sysclk) ctrlWen <= 1'b0;
        @(negedge sysclk);
    endtask

    task automatic runRow(input rowT r);
        logic [15:0] got;
        logic [15:0] exp;
        got   = 16'h0000;
        inDma = r.dma;
        if (!r.isCtrl) begin
            @(posedge sysclk);
            cmdReq  <= 1'b1;
            isDma   <= r.dma;
            isWrite <= r.wr;
            isWord  <= r.word;
            regAddr <= r.off;
            dataIn  <= r.data;
            while (!cmdAck) @(negedge sysclk);
            if (r.wr) begin
                while (!isIdle) @(negedge sysclk);
            end else begin
                while (!dataValid) @(negedge sysclk);
                got = dataOut;
            end
            @(posedge sysclk) cmdReq <= 1'b0;
            @(negedge sysclk);
            while (cmdAck) @(negedge sysclk);
            checkFlag("dataValid", dataValid, 1'b0);
        end else begin
            ctrlWrite({4'h0, r.dma, 1'b0, r.wr, r.word, r.off, r.data});
            while (!isIdle) @(negedge sysclk);
            @(negedge sysclk);   // chip model counts the access on the edge after the strobe
            got = ethData;
            checkFlag("dataValid", dataValid, 1'b0);   // ctrl reads stay off the host port
        end
        inDma = 1'b0;
        expAccess++;
        if (r.wr) begin
            if (r.dma) dmaExp.push_back(r.data);
            else mirrorWrite(r.off, r.word, r.data);
            if (r.isCtrl)
                checkWord("ethData", got, r.data);   // last written control data
        end else begin
            exp = r.dma ? dmaExp.pop_front() : mirrorRead(r.off, r.word);
            checkWord(r.isCtrl ? "ethData" : "dataOut", got, exp);
            checkWord("table expect", r.expRead, exp);
        end
        checkFlag("ethError", ethError, 1'b0);
    endtask

    // no address phase may show up on a DMA access
    always @(negedge sysclk)
        if (inDma) checkFlag("ethCmd", ethCmd, 1'b0);

    // watchdog budget of 40 cycles per row or scenario plus reset and two init sequences
    initial begin
        repeat ((NROWS + 2) * 40 + 10
                + 2 * (`ETH_RST_ASSERT_CYCLES + `ETH_RST_WAIT_CYCLES) + 100)
            @(posedge sysclk);
        $display("watchdog expired, the DUT stopped responding");
        $display("Test failed");
        $finish;
    end

    initial begin
        initAck   = 1'b0;
        cmdReq    = 1'b0;
        isDma     = 1'b0;
        isWrite   = 1'b0;
        isWord    = 1'b0;
        regAddr   = 8'h00;
        dataIn    = 16'h0000;
        ctrlWen   = 1'b0;
        ctrlAddr  = 16'h0000;
        ctrlWdata = 32'h0;
        for (int i = 0; i < 256; i++)
            mirror[i] = i[7:0] ^ 8'h5a;
        //                ctrl  dma   wr    word  off    data      expect
        rows[0]  = '{1'b0, 1'b0, 1'b1, 1'b1, 8'h10, 16'h1234, 16'h0000};
        rows[1]  = '{1'b0, 1'b0, 1'b1, 1'b0, 8'h12, 16'h0056, 16'h0000};
        rows[2]  = '{1'b0, 1'b0, 1'b1, 1'b0, 8'h13, 16'hab00, 16'h0000};
        rows[3]  = '{1'b0, 1'b0, 1'b0, 1'b1, 8'h10, 16'h0000, 16'h1234};
        rows[4]  = '{1'b0, 1'b0, 1'b0, 1'b1, 8'h12, 16'h0000, 16'hab56};
        rows[5]  = '{1'b0, 1'b0, 1'b0, 1'b0, 8'h11, 16'h0000, 16'h1200};
        rows[6]  = '{1'b1, 1'b0, 1'b1, 1'b1, 8'h20, 16'hbeef, 16'h0000};
        rows[7]  = '{1'b1, 1'b0, 1'b1, 1'b0, 8'h21, 16'h5a00, 16'h0000};
        rows[8]  = '{1'b1, 1'b0, 1'b0, 1'b1, 8'h20, 16'h0000, 16'h5aef};
        rows[9]  = '{1'b1, 1'b0, 1'b0, 1'b0, 8'h20, 16'h0000, 16'h00ef};
        rows[10] = '{1'b0, 1'b1, 1'b1, 1'b1, 8'h00, 16'h1111, 16'h0000};
        rows[11] = '{1'b0, 1'b1, 1'b1, 1'b1, 8'h00, 16'h2222, 16'h0000};
        rows[12] = '{1'b1, 1'b1, 1'b1, 1'b1, 8'h00, 16'h3333, 16'h0000};
        rows[13] = '{1'b0, 1'b1, 1'b0, 1'b1, 8'h00, 16'h0000, 16'h1111};
        rows[14] = '{1'b1, 1'b1, 1'b0, 1'b1, 8'h00, 16'h0000, 16'h2222};
        rows[15] = '{1'b0, 1'b1, 1'b0, 1'b1, 8'h00, 16'h0000, 16'h3333};

        // state right after reset release
        @(posedge reset);
        @(negedge sysclk);
        checkFlag("ethRstn", ethRstn, 1'b0);
        checkFlag("ethWrn", ethWrn, 1'b1);
        checkFlag("ethRdn", ethRdn, 1'b1);
        checkFlag("initReq", initReq, 1'b0);
        checkFlag("cmdAck", cmdAck, 1'b0);
        checkFlag("dataValid", dataValid, 1'b0);
        checkFlag("ethError", ethError, 1'b0);
        ackInit();

        for (int i = 0; i < NROWS; i++) begin
            runRow(rows[i]);
            checkCount("accessCount", accessCount, expAccess);
        end

        // control write lands while a host write is busy and must be dropped
        @(posedge sysclk);
        cmdReq  <= 1'b1;
        isDma   <= 1'b0;
        isWrite <= 1'b1;
        isWord  <= 1'b1;
        regAddr <= 8'h30;
        dataIn  <= 16'h7777;
        while (!cmdAck) @(negedge sysclk);
        ctrlWrite({4'h0, 1'b0, 1'b0, 1'b1, 1'b1, 8'h40, 16'h9999});
        checkFlag("ethError", ethError, 1'b1);
        while (!isIdle) @(negedge sysclk);
        @(posedge sysclk) cmdReq <= 1'b0;
        while (cmdAck) @(negedge sysclk);
        expAccess++;
        checkCount("accessCount", accessCount, expAccess);

        // restart through the reset flag
        ctrlWrite({4'h0, 1'b0, 1'b1, 1'b0, 1'b0, 8'h00, 16'h0000});
        checkFlag("ethRstn", ethRstn, 1'b0);
        checkFlag("ethError", ethError, 1'b0);
        checkFlag("initReq", initReq, 1'b0);
        ackInit();
        checkFlag("badAccess", badAccess, 1'b0);
        checkCount("accessCount", accessCount, expAccess);

        $display("errors: %0d value mismatches, model fault %0b", valueErrors, badAccess);
        if (valueErrors == 0 && !badAccess) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+.
ethBusPkg.sv
ethReqIf.sv
ethReqArbiter.sv
ethBusEngine.sv
ksz8851Ctrl.sv
tbClock.sv
ksz8851Model.sv
ksz8851Tb.sv

// ==== runSim.sh ====
#!/bin/bash
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module ksz8851Tb -f sim.f -o simv

out=$(./obj_dir/simv)
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
    exit 0
else
    exit 1
fi
